/* filelist.f */
+incdir+hw
hw/rv_pkg.sv
hw/RegisterFile.sv
hw/ImmGen.sv
hw/WritebackSelect.sv
hw/Decoder.sv
tests/Decoder_assertions.sv
tests/DecoderTb.sv

/* hw/Decoder.sv */
`timescale 1ns/10ps
`include "rv_config.svh"

module Decoder (
    input  logic              clk,
    input  logic              rst,
    // From the fetch stage
    input  rv_pkg::instWord_t inst,
    // From the write-back stage
    input  logic [2:0]        wbFunct3,
    input  rv_pkg::regAddr_t  wbRdAddr,
    input  rv_pkg::word_t     aluResult,
    input  rv_pkg::word_t     memData,
    input  rv_pkg::word_t     pcPlus4,
    input  logic              regWrite,
    input  logic              memToReg,
    input  logic              wbLink,
    // Operands and fields
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2,
    output rv_pkg::word_t     imm32,
    output logic [2:0]        funct3,
    output logic [6:0]        funct7,
    output rv_pkg::regAddr_t  rs1Addr,
    output rv_pkg::regAddr_t  rs2Addr,
    output rv_pkg::regAddr_t  rdAddr,
    // Environment call
    output rv_pkg::word_t     ecallCode,
    output rv_pkg::word_t     ecallArg
);
    import rv_pkg::*;

    // Value heading into the register file
    word_t wdata;

    // --------------------------------------------------
    // Field extraction
    // --------------------------------------------------
    // R view covers every register and function field
    // Unused fields are don't-care for the later stages
    assign rs1Addr = inst.r.rs1;
    assign rs2Addr = inst.r.rs2;
    assign rdAddr  = inst.r.rd;
    assign funct3  = inst.r.funct3;
    assign funct7  = inst.r.funct7;

    // --------------------------------------------------
    // Write-back path
    // --------------------------------------------------
    // Link decision comes with the write-back stage flags
    WritebackSelect uWritebackSelect (
        .wbFunct3  (wbFunct3),
        .aluResult (aluResult),
        .memData   (memData),
        .pcPlus4   (pcPlus4),
        .memToReg  (memToReg),
        .wbLink    (wbLink),
        .wdata     (wdata)
    );

    // --------------------------------------------------
    // Register file
    // --------------------------------------------------
    // a7 holds the call number, a0 the argument
    RegisterFile uRegisterFile (
        .clk      (clk),
        .rst      (rst),
        .raddr1   (rs1Addr),
        .raddr2   (rs2Addr),
        .waddr    (wbRdAddr),
        .wdata    (wdata),
        .regWrite (regWrite),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .a7Data   (ecallCode),
        .a0Data   (ecallArg)
    );

    // --------------------------------------------------
    // Immediate
    // --------------------------------------------------
    ImmGen uImmGen (
        .inst  (inst),
        .imm32 (imm32)
    );

endmodule

/* hw/ImmGen.sv */
`timescale 1ns/10ps
`include "rv_config.svh"

module ImmGen (
    input  rv_pkg::instWord_t inst,
    output rv_pkg::word_t     imm32
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic       sign;
    word_t      immI;
    word_t      immS;
    word_t      immB;
    word_t      immU;
    word_t      immJ;

    // Opcode sits at the same place in every format
    assign opcode = inst.r.opcode;
    // Sign of every immediate is instruction bit 31
    assign sign   = inst.raw[31];

    // --------------------------------------------------
    // Per-format immediates
    // --------------------------------------------------
    assign immI = {{20{sign}}, inst.i.imm11_0};
    assign immS = {{20{sign}}, inst.s.imm11_5, inst.s.imm4_0};

    // Branch offset is even, bit 0 forced low
    assign immB = {{19{sign}}, inst.b.imm12, inst.b.imm11,
                   inst.b.imm10_5, inst.b.imm4_1, 1'b0};

    // Upper immediate, low 12 bits zero
    assign immU = {inst.u.imm31_12, 12'b0};

    // Jump offset, also even
    assign immJ = {{11{sign}}, inst.j.imm20, inst.j.imm19_12,
                   inst.j.imm11, inst.j.imm10_1, 1'b0};

    // --------------------------------------------------
    // Format select by opcode
    // --------------------------------------------------
    always_comb begin
        case (opcode)
            `OPCODE_LOAD,
            `OPCODE_OPIMM,
            `OPCODE_JALR,
            `OPCODE_SYSTEM: imm32 = immI;
            `OPCODE_STORE:  imm32 = immS;
            `OPCODE_BRANCH: imm32 = immB;
            `OPCODE_LUI,
            `OPCODE_AUIPC:  imm32 = immU;
            `OPCODE_JAL:    imm32 = immJ;
            // R-type and unknown opcodes carry no immediate
            default:        imm32 = '0;
        endcase
    end

endmodule

/* hw/RegisterFile.sv */
`timescale 1ns/10ps
`include "rv_config.svh"

module RegisterFile (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::regAddr_t raddr1,
    input  rv_pkg::regAddr_t raddr2,
    input  rv_pkg::regAddr_t waddr,
    input  rv_pkg::word_t    wdata,
    input  logic             regWrite,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2,
    output rv_pkg::word_t    a7Data,
    output rv_pkg::word_t    a0Data
);
    import rv_pkg::*;

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    // x0 has no storage, it is hardwired to zero
    word_t regs [1:`REG_COUNT-1];
    logic  writeValid;

    // Writes to x0 are dropped
    assign writeValid = regWrite && (waddr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeValid) begin
            regs[waddr] <= wdata;
        end
    end

    // --------------------------------------------------
    // Read ports
    // --------------------------------------------------
    // Shared by both ports
    // Same-cycle write wins over the stored value
    function automatic word_t readPort(input regAddr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (writeValid && (addr == waddr)) begin
            value = wdata;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rdata1 = readPort(raddr1);
        rdata2 = readPort(raddr2);
    end

    // --------------------------------------------------
    // Environment-call taps
    // --------------------------------------------------
    // Straight from storage, so a write shows up one cycle later
    assign a7Data = regs[`REG_A7];
    assign a0Data = regs[`REG_A0];

endmodule

/* hw/WritebackSelect.sv */
`timescale 1ns/10ps
`include "rv_config.svh"

module WritebackSelect (
    input  logic [2:0]    wbFunct3,
    input  rv_pkg::word_t aluResult,
    input  rv_pkg::word_t memData,
    input  rv_pkg::word_t pcPlus4,
    input  logic          memToReg,
    input  logic          wbLink,
    output rv_pkg::word_t wdata
);
    import rv_pkg::*;

    word_t loadData;

    // --------------------------------------------------
    // Load extension
    // --------------------------------------------------
    // Memory returns the addressed bytes right-aligned
    always_comb begin
        case (wbFunct3)
            // Byte, sign from bit 7
            `INST_LB:  loadData = {{24{memData[7]}}, memData[7:0]};
            // Halfword, sign from bit 15
            `INST_LH:  loadData = {{16{memData[15]}}, memData[15:0]};
            `INST_LW:  loadData = memData;
            // Unsigned variants
            `INST_LBU: loadData = {24'b0, memData[7:0]};
            `INST_LHU: loadData = {16'b0, memData[15:0]};
            // Not a load width
            default:   loadData = '0;
        endcase
    end

    // --------------------------------------------------
    // Source select
    // --------------------------------------------------
    // Link address first, then load data, then ALU
    always_comb begin
        if (wbLink) begin
            wdata = pcPlus4;
        end else if (memToReg) begin
            wdata = loadData;
        end else begin
            wdata = aluResult;
        end
    end

endmodule

/* hw/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// --------------------------------------------------
// Architectural sizes (fixed by RV32I)
// --------------------------------------------------
`define XLEN       32
`define REG_COUNT  32

// Major opcodes, bits [6:0] of the instruction
`define OPCODE_LUI     7'b0110111
`define OPCODE_AUIPC   7'b0010111
`define OPCODE_JAL     7'b1101111
`define OPCODE_JALR    7'b1100111
`define OPCODE_BRANCH  7'b1100011
`define OPCODE_LOAD    7'b0000011
`define OPCODE_STORE   7'b0100011
`define OPCODE_OPIMM   7'b0010011
`define OPCODE_OP      7'b0110011
`define OPCODE_SYSTEM  7'b1110011

// Load widths, funct3 of the load instruction
`define INST_LB   3'b000
`define INST_LH   3'b001
`define INST_LW   3'b010
`define INST_LBU  3'b100
`define INST_LHU  3'b101

// ABI registers used by the environment call
`define REG_A0  5'd10
`define REG_A7  5'd17

`endif

/* hw/rv_pkg.sv */
`include "rv_config.svh"

package rv_pkg;

    // --------------------------------------------------
    // Basic types
    // --------------------------------------------------
    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] regAddr_t;

    // --------------------------------------------------
    // Instruction formats, MSB first
    // --------------------------------------------------
    // Register-register
    typedef struct packed {
        logic [6:0] funct7;
        regAddr_t   rs2;
        regAddr_t   rs1;
        logic [2:0] funct3;
        regAddr_t   rd;
        logic [6:0] opcode;
    } rFields_t;

    // Register-immediate, loads, JALR, SYSTEM
    typedef struct packed {
        logic [11:0] imm11_0;
        regAddr_t    rs1;
        logic [2:0]  funct3;
        regAddr_t    rd;
        logic [6:0]  opcode;
    } iFields_t;

    // Stores
    typedef struct packed {
        logic [6:0] imm11_5;
        regAddr_t   rs2;
        regAddr_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } sFields_t;

    // Branches, scrambled offset in halfwords
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        regAddr_t   rs2;
        regAddr_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } bFields_t;

    // LUI and AUIPC
    typedef struct packed {
        logic [19:0] imm31_12;
        regAddr_t    rd;
        logic [6:0]  opcode;
    } uFields_t;

    // JAL
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        regAddr_t   rd;
        logic [6:0] opcode;
    } jFields_t;

    // One fetched word, read through whichever format applies
    typedef union packed {
        logic [31:0] raw;
        rFields_t    r;
        iFields_t    i;
        sFields_t    s;
        bFields_t    b;
        uFields_t    u;
        jFields_t    j;
    } instWord_t;

endpackage

/* tests/DecoderTb.sv */
`timescale 1ns/10ps
`include "rv_config.svh"

module DecoderTb;
    import rv_pkg::*;

    localparam int Period = 4;
    // Reset, reset reads, writes, bypass, immediates, write-back, ecall
    localparam int TestCycles = 4 + 32 + 63 + 16 + 60 + 24 + 8;
    localparam int MarginCycles = 100;

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic [2:0]  wbFunct3;
    regAddr_t    wbRdAddr;
    word_t       aluResult, memData, pcPlus4;
    logic        regWrite, memToReg, wbLink;
    word_t       rdata1, rdata2, imm32, ecallCode, ecallArg;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    regAddr_t    rs1Addr, rs2Addr, rdAddr;

    // Expected register contents
    word_t       model [0:31];
    int          checkCount;
    int          errorCount;
    int unsigned seedDummy;

    Decoder dut_i (.*);

    initial clk = 1'b0;
    always #(Period / 2) clk = ~clk;

    // Watchdog
    initial begin
        #((TestCycles + MarginCycles) * Period);
        $display("Watchdog timeout, the tests did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Reference models, straight from the RV32I encoding
    // --------------------------------------------------
    function automatic word_t decodeImm(input logic [31:0] w);
        word_t value;
        case (w[6:0])
            `OPCODE_LOAD, `OPCODE_OPIMM, `OPCODE_JALR, `OPCODE_SYSTEM:
                value = {{20{w[31]}}, w[31:20]};
            `OPCODE_STORE:  value = {{20{w[31]}}, w[31:25], w[11:7]};
            `OPCODE_BRANCH: value = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            `OPCODE_LUI, `OPCODE_AUIPC: value = {w[31:12], 12'h000};
            `OPCODE_JAL:    value = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:        value = '0;
        endcase
        return value;
    endfunction

    // Mask, then fill the upper bits for signed widths
    function automatic word_t extendLoad(input logic [2:0] f3, input word_t mem);
        word_t value;
        value = '0;
        if (f3 == `INST_LB || f3 == `INST_LBU) value = mem & 32'h0000_00ff;
        if (f3 == `INST_LH || f3 == `INST_LHU) value = mem & 32'h0000_ffff;
        if (f3 == `INST_LW) value = mem;
        if (f3 == `INST_LB && mem[7]) value = value | 32'hffff_ff00;
        if (f3 == `INST_LH && mem[15]) value = value | 32'hffff_0000;
        return value;
    endfunction

    task automatic checkValue(input string name, input word_t expected, input word_t actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // --------------------------------------------------
    // Bus-free drivers
    // --------------------------------------------------
    // Write lands on the second edge
    task automatic writeBack(input regAddr_t addr, input logic [2:0] f3, input word_t alu,
                             input word_t mem, input word_t pc, input logic m2r,
                             input logic link, input word_t expected);
        @(posedge clk);
        regWrite  <= 1'b1;
        wbRdAddr  <= addr;
        wbFunct3  <= f3;
        aluResult <= alu;
        memData   <= mem;
        pcPlus4   <= pc;
        memToReg  <= m2r;
        wbLink    <= link;
        @(posedge clk);
        regWrite <= 1'b0;
        memToReg <= 1'b0;
        wbLink   <= 1'b0;
        if (addr != '0) model[addr] = expected;
    endtask

    task automatic readPair(input regAddr_t addr1, input regAddr_t addr2);
        @(posedge clk);
        inst <= {7'b0, addr2, addr1, 3'b0, 5'b0, `OPCODE_OP};
        @(negedge clk);
        checkValue("rdata1", model[addr1], rdata1);
        checkValue("rdata2", model[addr2], rdata2);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic resetContents();
        for (int a = 0; a < 32; a++) readPair(a, 31 - a);
        checkValue("ecallCode", '0, ecallCode);
        checkValue("ecallArg", '0, ecallArg);
    endtask

    task automatic writeThenRead();
        regAddr_t addr;
        word_t    data;
        // Alternate ports so both read the stored value
        for (int n = 0; n < 20; n++) begin
            addr = $urandom_range(31, 1);
            data = $urandom();
            writeBack(addr, `INST_LW, data, '0, '0, 1'b0, 1'b0, data);
            if (n % 2 == 0) begin
                readPair(addr, $urandom_range(31, 0));
            end else begin
                readPair($urandom_range(31, 0), addr);
            end
        end
        // x0 ignores writes
        writeBack('0, `INST_LW, $urandom(), '0, '0, 1'b0, 1'b0, '0);
        readPair('0, '0);
    endtask

    task automatic sameCycleBypass();
        regAddr_t addr;
        word_t    data;
        repeat (8) begin
            addr = $urandom_range(31, 1);
            data = $urandom();
            @(posedge clk);
            regWrite  <= 1'b1;
            wbRdAddr  <= addr;
            aluResult <= data;
            inst      <= {7'b0, addr, addr, 3'b0, 5'b0, `OPCODE_OP};
            @(negedge clk);
            checkValue("rdata1", data, rdata1);
            checkValue("rdata2", data, rdata2);
            @(posedge clk);
            regWrite <= 1'b0;
            model[addr] = data;
        end
    endtask

    task automatic immediatesAndFields();
        logic [6:0]  opList [10] = '{`OPCODE_LUI, `OPCODE_AUIPC, `OPCODE_JAL, `OPCODE_JALR,
                                     `OPCODE_BRANCH, `OPCODE_LOAD, `OPCODE_STORE,
                                     `OPCODE_OPIMM, `OPCODE_OP, `OPCODE_SYSTEM};
        logic [31:0] w;
        foreach (opList[k]) begin
            repeat (6) begin
                w = $urandom();
                w[6:0] = opList[k];
                @(posedge clk);
                inst <= w;
                @(negedge clk);
                checkValue("imm32", decodeImm(w), imm32);
                checkValue("rs1Addr", w[19:15], rs1Addr);
                checkValue("rs2Addr", w[24:20], rs2Addr);
                checkValue("rdAddr", w[11:7], rdAddr);
                checkValue("funct3", w[14:12], funct3);
                checkValue("funct7", w[31:25], funct7);
            end
        end
    endtask

    task automatic writebackSources();
        // Last code is not a load width
        logic [2:0] codes [6] = '{`INST_LB, `INST_LH, `INST_LW, `INST_LBU, `INST_LHU, 3'b011};
        regAddr_t   addr;
        word_t      alu, mem, pc;
        foreach (codes[k]) begin
            addr = $urandom_range(31, 1);
            alu = $urandom();
            mem = $urandom();
            writeBack(addr, codes[k], alu, mem, $urandom(), 1'b1, 1'b0, extendLoad(codes[k], mem));
            readPair(addr, '0);
        end
        // Link beats load data
        addr = $urandom_range(31, 1);
        pc = $urandom();
        writeBack(addr, `INST_LW, $urandom(), $urandom(), pc, 1'b1, 1'b1, pc);
        readPair(addr, '0);
        alu = $urandom();
        writeBack(addr, `INST_LW, alu, $urandom(), pc, 1'b0, 1'b0, alu);
        readPair(addr, '0);
    endtask

    // Taps show the old value until the write edge has passed
    task automatic ecallTaps();
        regAddr_t taps [4] = '{`REG_A7, `REG_A0, `REG_A0, `REG_A7};
        word_t    data;
        foreach (taps[k]) begin
            data = $urandom();
            @(posedge clk);
            regWrite  <= 1'b1;
            wbRdAddr  <= taps[k];
            aluResult <= data;
            @(negedge clk);
            checkValue("ecallCode", model[`REG_A7], ecallCode);
            checkValue("ecallArg", model[`REG_A0], ecallArg);
            @(posedge clk);
            regWrite <= 1'b0;
            model[taps[k]] = data;
            @(negedge clk);
            checkValue("ecallCode", model[`REG_A7], ecallCode);
            checkValue("ecallArg", model[`REG_A0], ecallArg);
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        seedDummy = $urandom(3663);
        rst = 1'b1;
        inst = '0;
        wbFunct3 = '0;
        wbRdAddr = '0;
        aluResult = '0;
        memData = '0;
        pcPlus4 = '0;
        regWrite = 1'b0;
        memToReg = 1'b0;
        wbLink = 1'b0;
        checkCount = 0;
        errorCount = 0;
        foreach (model[i]) model[i] = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        resetContents();
        writeThenRead();
        sameCycleBypass();
        immediatesAndFields();
        writebackSources();
        ecallTaps();
        @(negedge clk);
        errorCount += dut_i.uDecoderAssertions.failCount;
        $display("Checks: %0d  errors: %0d  (assertion failures: %0d)",
                 checkCount, errorCount, dut_i.uDecoderAssertions.failCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* tests/Decoder_assertions.sv */
`timescale 1ns/10ps

module DecoderAssertions (
    input logic             clk,
    input logic             rst,
    input logic [31:0]      inst,
    input logic             regWrite,
    input rv_pkg::regAddr_t wbRdAddr,
    input rv_pkg::word_t    wdata,
    input rv_pkg::regAddr_t rs1Addr,
    input rv_pkg::regAddr_t rs2Addr,
    input rv_pkg::regAddr_t rdAddr,
    input logic [2:0]       funct3,
    input rv_pkg::word_t    rdata1,
    input rv_pkg::word_t    rdata2
);
    // Read by the testbench at the end of the run
    int failCount = 0;

    // --------------------------------------------------
    // x0 stays zero on both ports
    // --------------------------------------------------
    zeroPort1: assert property (@(posedge clk) (rs1Addr == '0) |-> (rdata1 == '0))
        else begin
            failCount++;
            $error("Register 0 read nonzero on port 1: %h", rdata1);
        end

    zeroPort2: assert property (@(posedge clk) (rs2Addr == '0) |-> (rdata2 == '0))
        else begin
            failCount++;
            $error("Register 0 read nonzero on port 2: %h", rdata2);
        end

    // --------------------------------------------------
    // Stored value visible one cycle after the write
    // --------------------------------------------------
    // Skipped when a newer write to the same register is bypassed
    storedPort1: assert property (@(posedge clk) disable iff (rst)
        ($past(regWrite) && ($past(wbRdAddr) != '0) && !$past(rst)
            && (rs1Addr == $past(wbRdAddr)) && !(regWrite && (wbRdAddr == rs1Addr)))
        |-> (rdata1 == $past(wdata)))
        else begin
            failCount++;
            $error("Port 1 lost the write to x%0d", rs1Addr);
        end

    storedPort2: assert property (@(posedge clk) disable iff (rst)
        ($past(regWrite) && ($past(wbRdAddr) != '0) && !$past(rst)
            && (rs2Addr == $past(wbRdAddr)) && !(regWrite && (wbRdAddr == rs2Addr)))
        |-> (rdata2 == $past(wdata)))
        else begin
            failCount++;
            $error("Port 2 lost the write to x%0d", rs2Addr);
        end

    // Field outputs are plain bit slices
    fieldSlices: assert property (@(posedge clk)
        (funct3 == inst[14:12]) && (rdAddr == inst[11:7]))
        else begin
            failCount++;
            $error("funct3 or rdAddr differs from the instruction bits");
        end

endmodule

bind Decoder DecoderAssertions uDecoderAssertions (
    .clk      (clk),
    .rst      (rst),
    .inst     (inst),
    .regWrite (regWrite),
    .wbRdAddr (wbRdAddr),
    .wdata    (wdata),
    .rs1Addr  (rs1Addr),
    .rs2Addr  (rs2Addr),
    .rdAddr   (rdAddr),
    .funct3   (funct3),
    .rdata1   (rdata1),
    .rdata2   (rdata2)
);
